// File: source/sifh_params.svh
// sizes shared by the RTL and the testbench
// Np must exceed Nb + 1 so that a coarse bin spans at least two values
// the widths below must fit the counts next to them
`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// timestamp width
`define Np 10
// bin index width, 2**Nb bins per histogram
`define Nb 4
`define binNum (1 << `Nb)

// pixel lanes and lane index width
`define pixelNum 4
`define pixelW 2

// samples per pixel per acquisition
`define dataNum 2
`define dataW 1

// acquisitions per pass
`define acqNum 8
`define acqW 3

// bin counter width, counters saturate
`define countWidth 8

// result port address width and frame counter width
`define rAdrW 3
`define frameW 16

`endif

// File: source/sifhPkg.sv
// types shared by the sequencer, the lanes and the collector
// field widths come from sifh_params.svh
`include "sifh_params.svh"

package sifhPkg;

    //**************************************************
    // enums
    //**************************************************

    // which histogram pass a sample belongs to
    typedef enum logic {
        coarsePass = 1'b0,
        finePass   = 1'b1
    } passT;

    // sequencer states
    typedef enum logic [1:0] {
        idle      = 2'd0,
        running   = 2'd1,
        waitDrain = 2'd2
    } seqStateT;

    //**************************************************
    // structs
    //**************************************************

    // one timestamp broadcast to every lane
    typedef struct packed {
        logic              valid;
        logic [`pixelW-1:0] pixel;
        passT              pass;
        logic [`Np-1:0]    ts;
    } sampleT;

    // frame strobes, one cycle each
    // frameStart only rises together with the fine passDone
    typedef struct packed {
        logic passDone;
        logic frameStart;
    } laneCtrlT;

    // one lane's peak, 19 bits
    typedef struct packed {
        logic                  peakValid;
        logic [`countWidth-1:0] peakCount;
        logic [`Np-1:0]        peakTime;
    } laneResultT;

endpackage

// File: source/sampleSequencer.sv
// sample port, accepts timestamps in pixel-major order per acquisition
// writes that would start a new frame stall until the results are drained
// the port has no data output, reads are acked only
`timescale 1ns/1ns
`include "sifh_params.svh"

module sampleSequencer
    import sifhPkg::*;
(
    input  logic            clk,
    input  logic            combin_res,
    input  logic            sCyc,
    input  logic            sStb,
    input  logic            sWe,
    input  logic [`Np-1:0]  sDat,
    output logic            sAck,
    input  logic            resultsPending,
    output sampleT          sample,
    output laneCtrlT        laneCtrl
);

    seqStateT            state;
    passT                curPass;
    logic [`dataW-1:0]   dataCnt;
    logic [`pixelW-1:0]  pixelCnt;
    logic [`acqW-1:0]    acqCnt;
    logic                sawPending;
    logic                stall;
    logic                acceptW;
    logic                lastOfPixel;
    logic                lastOfAcq;
    logic                lastOfPass;

    //**************************************************
    // decode
    //**************************************************
    always_comb begin
        // only writes stall, reads pass through
        stall = (state == waitDrain) && sWe;
        // data is still held by the master in the ack cycle
        acceptW = sAck && sCyc && sStb && sWe;
        lastOfPixel = (dataCnt == `dataW'(`dataNum - 1));
        lastOfAcq = lastOfPixel && (pixelCnt == `pixelW'(`pixelNum - 1));
        lastOfPass = lastOfAcq && (acqCnt == `acqW'(`acqNum - 1));
    end

    // single-cycle ack, one cycle after cyc and stb
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sAck <= 1'b0;
        end else begin
            sAck <= sCyc && sStb && !sAck && !stall;
        end
    end

    //**************************************************
    // counters and broadcast
    //**************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            dataCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
            curPass <= coarsePass;
            sample <= '0;
            laneCtrl <= '0;
        end else begin
            // sample tagged with the counters before they move
            sample.valid <= acceptW;
            sample.pixel <= pixelCnt;
            sample.pass <= curPass;
            sample.ts <= sDat;
            // strobes line up with the last sample of the pass
            laneCtrl.passDone <= acceptW && lastOfPass;
            laneCtrl.frameStart <= acceptW && lastOfPass && (curPass == finePass);
            if (acceptW) begin
                dataCnt <= lastOfPixel ? '0 : dataCnt + 1'b1;
                if (lastOfPixel) begin
                    pixelCnt <= lastOfAcq ? '0 : pixelCnt + 1'b1;
                end
                if (lastOfAcq) begin
                    acqCnt <= lastOfPass ? '0 : acqCnt + 1'b1;
                end
                // coarse to fine, fine back to coarse
                if (lastOfPass) begin
                    curPass <= (curPass == coarsePass) ? finePass : coarsePass;
                end
            end
        end
    end

    //**************************************************
    // frame FSM
    //**************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= idle;
            sawPending <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    // first write opens a frame
                    if (acceptW) begin
                        state <= running;
                    end
                end
                running: begin
                    if (acceptW && lastOfPass && (curPass == finePass)) begin
                        state <= waitDrain;
                    end
                end
                waitDrain: begin
                    // pending rises a few cycles after the fine pass ends
                    if (resultsPending) begin
                        sawPending <= 1'b1;
                    end
                    if (sawPending && !resultsPending) begin
                        sawPending <= 1'b0;
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// File: source/histogramLane.sv
// one pixel lane, coarse histogram then fine histogram in a 2**Nb window
// expects passDone in the cycle of the last sample of a pass
// and at least one idle cycle before the first sample of the next pass
`timescale 1ns/1ns
`include "sifh_params.svh"

module histogramLane
    import sifhPkg::*;
#(
    parameter int laneId = 0
)(
    input  logic        clk,
    input  logic        combin_res,
    input  sampleT      sample,
    input  laneCtrlT    laneCtrl,
    output laneResultT  result,
    output logic        laneDone
);

    // half a coarse bin, half the fine window, highest lower edge
    localparam int halfBin = 1 << (`Np - `Nb - 1);
    localparam int halfWin = 1 << (`Nb - 1);
    localparam int maxLow = (1 << `Np) - (1 << `Nb);

    logic [`countWidth-1:0] binMem [`binNum];
    logic [`binNum-1:0]     written;
    logic                   hit;
    logic                   take;
    logic [`Np:0]           diff;
    logic                   inWindow;
    logic [`Nb-1:0]         addr;
    logic [`countWidth-1:0] stored;
    logic [`countWidth-1:0] nextCount;
    logic                   s1Valid;
    logic [`Nb-1:0]         s1Addr;
    logic [`countWidth-1:0] s1Count;
    logic [`countWidth-1:0] peakCount;
    logic [`Nb-1:0]         peakBin;
    logic [`Nb-1:0]         finalBin;
    logic [`Np-1:0]         lowEdge;
    logic                   coarseDone;
    logic                   fineDone1;
    logic                   fineDone2;
    logic                   clearHist;
    int                     centre;
    int                     lowCalc;

    //**************************************************
    // filter and bin address
    //**************************************************
    always_comb begin
        hit = sample.valid && (sample.pixel == `pixelW'(laneId));
        // extra top bit catches timestamps below the window
        diff = {1'b0, sample.ts} - {1'b0, lowEdge};
        inWindow = !diff[`Np] && (diff[`Np-1:`Nb] == '0);
        if (sample.pass == coarsePass) begin
            addr = sample.ts[`Np-1 -: `Nb];
        end else begin
            addr = diff[`Nb-1:0];
        end
        take = hit && ((sample.pass == coarsePass) || inWindow);
        // in-flight update to the same bin is forwarded
        if (s1Valid && (s1Addr == addr)) begin
            stored = s1Count;
        end else if (written[addr]) begin
            stored = binMem[addr];
        end else begin
            stored = '0;
        end
        nextCount = (&stored) ? stored : stored + 1'b1;
    end

    //**************************************************
    // window arithmetic
    //**************************************************
    always_comb begin
        // peak including the commit still in flight
        finalBin = (s1Valid && (s1Count > peakCount)) ? s1Addr : peakBin;
        centre = (int'(finalBin) << (`Np - `Nb)) + halfBin;
        // clamp so the window stays inside the timestamp range
        if (centre < halfWin) begin
            lowCalc = 0;
        end else if (centre - halfWin > maxLow) begin
            lowCalc = maxLow;
        end else begin
            lowCalc = centre - halfWin;
        end
        clearHist = coarseDone || fineDone2;
    end

    // bin storage and stage-1 payload
    always_ff @(posedge clk) begin
        s1Addr <= addr;
        s1Count <= nextCount;
        if (s1Valid) begin
            binMem[s1Addr] <= s1Count;
        end
    end

    //**************************************************
    // flags, peak tracker, result
    //**************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            written <= '0;
            s1Valid <= 1'b0;
            peakCount <= '0;
            peakBin <= '0;
            lowEdge <= '0;
            coarseDone <= 1'b0;
            fineDone1 <= 1'b0;
            fineDone2 <= 1'b0;
            result <= '0;
            laneDone <= 1'b0;
        end else begin
            s1Valid <= take;
            // frameStart marks the fine passDone
            coarseDone <= laneCtrl.passDone && !laneCtrl.frameStart;
            fineDone1 <= laneCtrl.passDone && laneCtrl.frameStart;
            fineDone2 <= fineDone1;
            laneDone <= fineDone2;
            if (clearHist) begin
                // whole histogram empties in one cycle
                written <= '0;
                peakCount <= '0;
                peakBin <= '0;
            end else if (s1Valid) begin
                written[s1Addr] <= 1'b1;
                // strictly greater, earliest bin keeps a tie
                if (s1Count > peakCount) begin
                    peakCount <= s1Count;
                    peakBin <= s1Addr;
                end
            end
            if (coarseDone) begin
                lowEdge <= `Np'(lowCalc);
            end
            // fine peak is settled one cycle after the last commit
            if (fineDone2) begin
                result.peakValid <= (peakCount != '0);
                result.peakCount <= peakCount;
                result.peakTime <= lowEdge + {{(`Np-`Nb){1'b0}}, peakBin};
            end
        end
    end

endmodule

// File: source/peakCollector.sv
// result port, read only
// status at address 0, bit 31 pending and the frame count in the low bits
// lane p at address 1+p, reading the last lane clears pending
`timescale 1ns/1ns
`include "sifh_params.svh"

module peakCollector
    import sifhPkg::*;
(
    input  logic                          clk,
    input  logic                          combin_res,
    input  laneResultT [`pixelNum-1:0]    laneResults,
    input  logic                          laneDone,
    input  logic                          rCyc,
    input  logic                          rStb,
    input  logic [`rAdrW-1:0]             rAdr,
    output logic [31:0]                   rDatOut,
    output logic                          rAck,
    output logic                          resultsPending
);

    laneResultT [`pixelNum-1:0] held;
    logic [`frameW-1:0]         frameCount;
    logic                       readStart;
    logic                       lastRead;
    logic [31:0]                readWord;

    //**************************************************
    // read decode
    //**************************************************
    always_comb begin
        readStart = rCyc && rStb && !rAck;
        lastRead = readStart && (rAdr == `rAdrW'(`pixelNum));
        readWord = '0;
        if (rAdr == '0) begin
            readWord = {resultsPending, {(31 - `frameW){1'b0}}, frameCount};
        end else if (rAdr <= `rAdrW'(`pixelNum)) begin
            readWord = 32'(held[rAdr - 1'b1]);
        end
    end

    // lane 0 stands for all lanes
    always_ff @(posedge clk) begin
        if (laneDone) begin
            held <= laneResults;
        end
        if (readStart) begin
            rDatOut <= readWord;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rAck <= 1'b0;
            resultsPending <= 1'b0;
            frameCount <= '0;
        end else begin
            rAck <= readStart;
            // a new frame wins over a clearing read
            if (laneDone) begin
                resultsPending <= 1'b1;
                frameCount <= frameCount + 1'b1;
            end else if (lastRead) begin
                resultsPending <= 1'b0;
            end
        end
    end

endmodule

// File: source/sifhTop.sv
// two-pass histogram peak finder
// sample port in, result port out, both Wishbone classic slaves
// every lane finishes together, so lane 0's laneDone drives the collector
`timescale 1ns/1ns
`include "sifh_params.svh"

module sifhTop
    import sifhPkg::*;
(
    input  logic            clk,
    input  logic            combin_res,
    input  logic            sCyc,
    input  logic            sStb,
    input  logic            sWe,
    input  logic [`Np-1:0]  sDat,
    output logic            sAck,
    input  logic            rCyc,
    input  logic            rStb,
    input  logic [2:0]      rAdr,
    output logic [31:0]     rDatOut,
    output logic            rAck
);

    sampleT                     sample;
    laneCtrlT                   laneCtrl;
    laneResultT [`pixelNum-1:0] laneResults;
    logic [`pixelNum-1:0]       laneDoneVec;
    logic                       resultsPending;

    //**************************************************
    // sample side
    //**************************************************
    sampleSequencer sampleSequencer_i (
        .clk            (clk),
        .combin_res     (combin_res),
        .sCyc           (sCyc),
        .sStb           (sStb),
        .sWe            (sWe),
        .sDat           (sDat),
        .sAck           (sAck),
        .resultsPending (resultsPending),
        .sample         (sample),
        .laneCtrl       (laneCtrl)
    );

    // one lane per pixel
    for (genvar i = 0; i < `pixelNum; i++) begin : genLane
        histogramLane #(
            .laneId (i)
        ) histogramLane_i (
            .clk        (clk),
            .combin_res (combin_res),
            .sample     (sample),
            .laneCtrl   (laneCtrl),
            .result     (laneResults[i]),
            .laneDone   (laneDoneVec[i])
        );
    end

    //**************************************************
    // result side
    //**************************************************
    peakCollector peakCollector_i (
        .clk            (clk),
        .combin_res     (combin_res),
        .laneResults    (laneResults),
        .laneDone       (laneDoneVec[0]),
        .rCyc           (rCyc),
        .rStb           (rStb),
        .rAdr           (rAdr),
        .rDatOut        (rDatOut),
        .rAck           (rAck),
        .resultsPending (resultsPending)
    );

endmodule

// File: sim/clockGen.sv
// free-running 8 ns clock and a power-on reset, active low
// reset releases 1 ns after the fourth rising edge
`timescale 1ns/1ns

module clockGen #(
    parameter int halfPeriod = 4,
    parameter int resCycles = 4
)(
    output logic clk,
    output logic resN
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        resN = 1'b0;
        repeat (resCycles) @(posedge clk);
        #1 resN = 1'b1;
    end

endmodule

// File: sim/sifhTb.sv
// testbench for sifhTop, both ports driven 1 ns after the rising edge
// expected words come from a behavioral model of the two passes
// each frame is drained before the next one, except in backPressure
`timescale 1ns/1ns
`include "sifh_params.svh"

module sifhTb;

    localparam int perPass = `acqNum * `dataNum;
    localparam int coarseW = 1 << (`Np - `Nb);
    localparam int tsMax = (1 << `Np) - 1;
    localparam int maxLow = (1 << `Np) - `binNum;
    localparam int busTimeout = 200;
    localparam int pollLimit = 50;

    logic                clk;
    logic                porRes;
    logic                forceRes;
    logic                combin_res;
    logic                sCyc;
    logic                sStb;
    logic                sWe;
    logic [`Np-1:0]      sDat;
    logic                sAck;
    logic                rCyc;
    logic                rStb;
    logic [2:0]          rAdr;
    logic [31:0]         rDatOut;
    logic                rAck;

    // stimulus per pixel, index acq * dataNum + d
    logic [`Np-1:0]      coarseTs [`pixelNum][perPass];
    logic [`Np-1:0]      fineTs [`pixelNum][perPass];
    logic [31:0]         gotLane [`pixelNum];
    logic [31:0]         expA [`pixelNum];
    logic [31:0]         data;
    string               curTest;
    int                  passCount;
    int                  failCount;
    int                  testFails;
    int                  frames;
    int                  writesAcked;
    int                  waited;
    int                  seed;
    int                  tieLow;

    clockGen clockGen_i (
        .clk  (clk),
        .resN (porRes)
    );

    // power-on reset or a forced reset mid-frame
    assign combin_res = porRes && !forceRes;

    sifhTop sifhTop_i (
        .clk        (clk),
        .combin_res (combin_res),
        .sCyc       (sCyc),
        .sStb       (sStb),
        .sWe        (sWe),
        .sDat       (sDat),
        .sAck       (sAck),
        .rCyc       (rCyc),
        .rStb       (rStb),
        .rAdr       (rAdr),
        .rDatOut    (rDatOut),
        .rAck       (rAck)
    );

    //**************************************************
    // behavioral model
    //**************************************************

    // coarse peak, earliest bin to reach the max, then the clamped lower edge
    function automatic int modelLow(input int px);
        int cnt [`binNum];
        int best;
        int bestBin;
        int b;
        int low;
        for (int i = 0; i < `binNum; i++) cnt[i] = 0;
        best = 0;
        bestBin = 0;
        for (int k = 0; k < perPass; k++) begin
            b = int'(coarseTs[px][k]) / coarseW;
            cnt[b]++;
            if (cnt[b] > best) begin
                best = cnt[b];
                bestBin = b;
            end
        end
        low = bestBin * coarseW + coarseW / 2 - `binNum / 2;
        if (low < 0) low = 0;
        if (low > maxLow) low = maxLow;
        return low;
    endfunction

    // fine pass inside the window, packed as the result port word
    function automatic logic [31:0] modelResult(input int px);
        int cnt [`binNum];
        int low;
        int best;
        int bestBin;
        int off;
        low = modelLow(px);
        for (int i = 0; i < `binNum; i++) cnt[i] = 0;
        best = 0;
        bestBin = 0;
        for (int k = 0; k < perPass; k++) begin
            off = int'(fineTs[px][k]) - low;
            if (off >= 0 && off < `binNum) begin
                cnt[off]++;
                if (cnt[off] > best) begin
                    best = cnt[off];
                    bestBin = off;
                end
            end
        end
        return 32'({(best != 0), `countWidth'(best), `Np'(low + bestBin)});
    endfunction

    //**************************************************
    // stimulus helpers
    //**************************************************

    // every fourth sample anywhere, the rest within 3 of the centre
    function automatic logic [`Np-1:0] noisyTs(input int c, input int k);
        int v;
        if (k % 4 == 3) begin
            v = int'($urandom % (tsMax + 1));
        end else begin
            v = c + int'($urandom % 7) - 3;
        end
        if (v < 0) v = 0;
        if (v > tsMax) v = tsMax;
        return `Np'(v);
    endfunction

    // centre lands inside the fine window of its coarse bin
    task automatic fillCluster(input int px);
        int c;
        c = int'($urandom % `binNum) * coarseW + coarseW / 2 - 5 + int'($urandom % 10);
        for (int k = 0; k < perPass; k++) begin
            coarseTs[px][k] = noisyTs(c, k);
            fineTs[px][k] = noisyTs(c, k);
        end
    endtask

    // lower half of the pixels at the bottom of the range, upper half at the top
    task automatic fillEdges();
        for (int px = 0; px < `pixelNum; px++) begin
            for (int k = 0; k < perPass; k++) begin
                if (px < `pixelNum / 2) begin
                    coarseTs[px][k] = noisyTs(2, k);
                    fineTs[px][k] = `Np'($urandom % 48);
                end else begin
                    coarseTs[px][k] = noisyTs(tsMax - 2, k);
                    fineTs[px][k] = `Np'(tsMax - int'($urandom % 48));
                end
            end
        end
    endtask

    //**************************************************
    // bus tasks, entered and left 1 ns after an edge
    //**************************************************
    task automatic timeoutFail(input string what);
        $display("timeout in %s: %s", curTest, what);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic writeSample(input logic [`Np-1:0] ts);
        int waited;
        sCyc = 1'b1;
        sStb = 1'b1;
        sWe = 1'b1;
        sDat = ts;
        waited = 0;
        while (sAck !== 1'b1) begin
            if (waited >= busTimeout) timeoutFail("sample write never acked");
            @(posedge clk);
            #1;
            waited++;
        end
        writesAcked++;
        // hold through the ack cycle
        @(posedge clk);
        #1;
        sCyc = 1'b0;
        sStb = 1'b0;
        sWe = 1'b0;
    endtask

    task automatic readWordAt(input int adr, output logic [31:0] word);
        int waited;
        rCyc = 1'b1;
        rStb = 1'b1;
        rAdr = 3'(adr);
        waited = 0;
        while (rAck !== 1'b1) begin
            if (waited >= busTimeout) timeoutFail("result read never acked");
            @(posedge clk);
            #1;
            waited++;
        end
        word = rDatOut;
        @(posedge clk);
        #1;
        rCyc = 1'b0;
        rStb = 1'b0;
    endtask

    // full frame is two passes, stopAfter cuts it short
    task automatic runFrame(input int stopAfter);
        int n;
        n = 0;
        for (int pass = 0; pass < 2; pass++) begin
            for (int acq = 0; acq < `acqNum; acq++) begin
                for (int px = 0; px < `pixelNum; px++) begin
                    for (int d = 0; d < `dataNum; d++) begin
                        if (n == stopAfter) return;
                        if (pass == 0) begin
                            writeSample(coarseTs[px][acq * `dataNum + d]);
                        end else begin
                            writeSample(fineTs[px][acq * `dataNum + d]);
                        end
                        n++;
                    end
                end
            end
        end
    endtask

    //**************************************************
    // checks
    //**************************************************
    task automatic checkWord(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) begin
            passCount++;
        end else begin
            $display("mismatch %s %s: expected 0x%08h actual 0x%08h", curTest, what, exp, act);
            failCount++;
            testFails++;
        end
    endtask

    task automatic waitPending();
        logic [31:0] word;
        int polls;
        polls = 0;
        word = '0;
        while (!word[31]) begin
            if (polls >= pollLimit) timeoutFail("results never became pending");
            readWordAt(0, word);
            polls++;
        end
    endtask

    // status, then every lane, last lane read drains the frame
    task automatic checkFrame();
        logic [31:0] word;
        waitPending();
        readWordAt(0, word);
        checkWord("status", 32'h8000_0000 | 32'(frames), word);
        for (int p = 0; p < `pixelNum; p++) begin
            readWordAt(p + 1, word);
            gotLane[p] = word;
            checkWord($sformatf("lane %0d", p), modelResult(p), word);
        end
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testFails = 0;
    endtask

    task automatic endTest();
        if (testFails == 0) begin
            $display("test %s: ok", curTest);
        end else begin
            $display("test %s: %0d checks failed", curTest, testFails);
        end
    endtask

    //**************************************************
    // test sequence
    //**************************************************
    initial begin
        sCyc = 1'b0;
        sStb = 1'b0;
        sWe = 1'b0;
        sDat = '0;
        rCyc = 1'b0;
        rStb = 1'b0;
        rAdr = '0;
        forceRes = 1'b0;
        passCount = 0;
        failCount = 0;
        frames = 0;
        writesAcked = 0;
        curTest = "powerOn";
        seed = 45874;
        void'($urandom(seed));
        waited = 0;
        while (combin_res !== 1'b1) begin
            if (waited >= busTimeout) timeoutFail("reset never released");
            @(posedge clk);
            waited++;
        end
        @(posedge clk);
        #1;

        // empty status after reset, then clustered peaks
        startTest("clusterPeak");
        readWordAt(0, data);
        checkWord("status after reset", 32'h0, data);
        for (int px = 0; px < `pixelNum; px++) fillCluster(px);
        runFrame(-1);
        frames++;
        checkFrame();
        endTest();

        startTest("windowClamp");
        fillEdges();
        runFrame(-1);
        frames++;
        checkFrame();
        endTest();

        // pixel 2 fine samples all miss the window
        startTest("emptyFine");
        for (int px = 0; px < `pixelNum; px++) fillCluster(px);
        tieLow = modelLow(2);
        for (int k = 0; k < perPass; k++) begin
            if (tieLow >= (tsMax + 1) / 2) begin
                fineTs[2][k] = `Np'($urandom % 256);
            end else begin
                fineTs[2][k] = `Np'(768 + int'($urandom % 256));
            end
        end
        runFrame(-1);
        frames++;
        checkFrame();
        checkWord("lane 2 valid and count", 32'h0, gotLane[2] & 32'h0007_fc00);
        endTest();

        // pixel 1 fills window offset 11 first, then offset 2 to the same count
        startTest("tieRule");
        for (int px = 0; px < `pixelNum; px++) fillCluster(px);
        tieLow = modelLow(1);
        for (int k = 0; k < perPass; k++) begin
            fineTs[1][k] = `Np'((k < perPass / 2) ? tieLow + 11 : tieLow + 2);
        end
        runFrame(-1);
        frames++;
        checkFrame();
        checkWord("lane 1 tie time", 32'(tieLow + 11), gotLane[1] & 32'h0000_03ff);
        endTest();

        // second frame stalls until the last lane of the first is read
        startTest("backPressure");
        for (int px = 0; px < `pixelNum; px++) fillCluster(px);
        runFrame(-1);
        frames++;
        waitPending();
        readWordAt(0, data);
        checkWord("status first frame", 32'h8000_0000 | 32'(frames), data);
        for (int p = 0; p < `pixelNum; p++) expA[p] = modelResult(p);
        for (int px = 0; px < `pixelNum; px++) fillCluster(px);
        writesAcked = 0;
        fork
            runFrame(-1);
            begin
                repeat (12) begin
                    @(posedge clk);
                    #1;
                end
                for (int p = 0; p < `pixelNum; p++) begin
                    assert (writesAcked == 0) begin
                        passCount++;
                    end else begin
                        $display("%s: a new frame write was acked before the drain", curTest);
                        failCount++;
                        testFails++;
                    end
                    readWordAt(p + 1, data);
                    checkWord($sformatf("first frame lane %0d", p), expA[p], data);
                end
            end
        join
        frames++;
        checkFrame();
        endTest();

        // reset in the middle of the coarse pass
        startTest("resetMidFrame");
        for (int px = 0; px < `pixelNum; px++) fillCluster(px);
        runFrame(perPass * `pixelNum / 2 + 8);
        forceRes = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        forceRes = 1'b0;
        frames = 0;
        @(posedge clk);
        #1;
        readWordAt(0, data);
        checkWord("status after reset", 32'h0, data);
        for (int px = 0; px < `pixelNum; px++) fillCluster(px);
        runFrame(-1);
        frames++;
        checkFrame();
        endTest();

        $display("checks passed %0d failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: sifh.f
+incdir+source
source/sifhPkg.sv
source/sampleSequencer.sv
source/histogramLane.sv
source/peakCollector.sv
source/sifhTop.sv
sim/clockGen.sv
sim/sifhTb.sv

// File: Bender.yml
package:
  name: sifh

sources:
  - include_dirs:
      - source
    files:
      - source/sifhPkg.sv
      - source/sampleSequencer.sv
      - source/histogramLane.sv
      - source/peakCollector.sv
      - source/sifhTop.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/clockGen.sv
      - sim/sifhTb.sv
